/* Makefile */
# Verilator build and run for the l1 data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_cache
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST OK

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* l1_cache.sv */
// l1 data cache top: lookup, miss controller and data store between processor and memory
`timescale 1ns/1ps
`default_nettype none

module l1_cache (
    input  wire logic           CLK,
    input  wire logic           nRST,
    // processor side
    input  wire logic           proc_ren,
    input  wire logic           proc_wen,
    input  l1_cache_pkg::word_t proc_addr,
    input  l1_cache_pkg::word_t proc_wdata,
    output l1_cache_pkg::word_t proc_rdata,
    output logic                proc_busy,
    // memory side
    output logic                mem_ren,
    output logic                mem_wen,
    output l1_cache_pkg::word_t mem_addr,
    output l1_cache_pkg::word_t mem_wdata,
    input  l1_cache_pkg::word_t mem_rdata,
    input  wire logic           mem_busy
);
    import l1_cache_pkg::*;

    tag_t      req_tag;
    set_idx_t  req_set;
    word_idx_t req_word;
    logic      hit;
    logic      miss;
    way_t      hit_way;
    way_t      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    tag_t      way_tag [2];
    logic [1:0] way_valid;
    logic [1:0] way_dirty;
    way_t      lru_way;
    word_t     wb_data;
    logic      fill_we;
    word_idx_t fill_word_idx;
    word_t     fill_data;
    logic      fill_done;
    word_idx_t wb_word_idx;

    assign proc_busy = !hit;    // a hit completes in its first cycle

    l1_tag_lookup i_lookup (
        .proc_ren, .proc_wen, .proc_addr,
        .way_tag, .way_valid, .way_dirty, .lru_way,
        .req_tag, .req_set, .req_word,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .miss
    );

    l1_miss_ctrl i_miss_ctrl (
        .CLK, .nRST,
        .miss, .victim_dirty, .victim_tag, .req_tag, .req_set, .wb_data,
        .mem_rdata, .mem_busy,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata,
        .fill_we, .fill_word_idx, .fill_data, .fill_done, .wb_word_idx
    );

    l1_data_store i_data_store (
        .CLK, .nRST,
        .proc_wen, .proc_wdata,
        .hit, .hit_way, .victim_way, .req_set, .req_word, .req_tag,
        .fill_we, .fill_word_idx, .fill_data, .fill_done, .wb_word_idx,
        .way_tag, .way_valid, .way_dirty, .lru_way, .wb_data, .proc_rdata
    );

endmodule

`default_nettype wire

/* l1_cache_cfg.svh */
// l1 data cache configuration: geometry and bus widths shared by all blocks
`ifndef L1_CACHE_CFG_SVH
`define L1_CACHE_CFG_SVH

// data word width, one processor access
`define L1_WORD_BITS 32

// byte address width on both buses
`define L1_ADDR_BITS 32

// sets per way, power of two
`define L1_SETS 16

// words per block, power of two, max 8
`define L1_BLOCK_WORDS 2

`endif

/* l1_cache_input.txt */
// columns: op addr wdata exp_rdata fill_beats wb_beats (hex), op 1 = read, 2 = write
// set 1: first read, write hit, dirty eviction by two tags, reread from memory
1 00000008 00000000 a5a50008 2 0
2 00000008 deadbeef 00000000 0 0
1 00000008 00000000 deadbeef 0 0
1 0000000c 00000000 a5a5000c 0 0
1 00000088 00000000 a5a50088 2 0
1 00000108 00000000 a5a50108 2 2
1 00000008 00000000 deadbeef 2 0
1 0000000c 00000000 a5a5000c 0 0
// set 2: tags a b a c, then a hits and b refills
1 00000010 00000000 a5a50010 2 0
1 00000090 00000000 a5a50090 2 0
1 00000010 00000000 a5a50010 0 0
1 00000110 00000000 a5a50110 2 0
1 00000010 00000000 a5a50010 0 0
1 00000090 00000000 a5a50090 2 0
// set 4: write miss, both words dirty, evicted and read back
2 00000020 12345678 00000000 2 0
2 00000024 9abcdef0 00000000 0 0
1 000000a0 00000000 a5a500a0 2 0
1 00000120 00000000 a5a50120 2 2
1 00000024 00000000 9abcdef0 2 0
1 00000020 00000000 12345678 0 0
// set 15: top of the address space
2 fffffffc 0badf00d 00000000 2 0
1 fffffff8 00000000 5a5afff8 0 0
1 fffffffc 00000000 0badf00d 0 0
1 0000007c 00000000 a5a5007c 2 0
1 000000fc 00000000 a5a500fc 2 2
1 fffffffc 00000000 0badf00d 2 0
0 00000000 00000000 00000000 0 0

/* l1_cache_pkg.sv */
// l1 data cache package: address field types, word type and FSM/opcode enums
`default_nettype none

package l1_cache_pkg;

`include "l1_cache_cfg.svh"

    // address split widths, byte offset is fixed at 2 bits
    localparam int SET_BITS      = $clog2(`L1_SETS);
    localparam int WORD_IDX_BITS = $clog2(`L1_BLOCK_WORDS);
    localparam int TAG_BITS      = `L1_ADDR_BITS - SET_BITS - WORD_IDX_BITS - 2;

    typedef logic [`L1_WORD_BITS-1:0] word_t;     // data word or byte address
    typedef logic [SET_BITS-1:0]      set_idx_t;
    typedef logic [WORD_IDX_BITS-1:0] word_idx_t; // word within block
    typedef logic [TAG_BITS-1:0]      tag_t;
    typedef logic                     way_t;      // 2 ways only

    // miss controller, one state per burst
    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        FILL
    } miss_state_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } req_op_t;

endpackage

`default_nettype wire

/* l1_data_store.sv */
// l1 data store: valid, dirty, tag, data and LRU arrays with hit and fill writes
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_cfg.svh"

module l1_data_store (
    input  wire logic                 CLK,
    input  wire logic                 nRST,
    input  wire logic                 proc_wen,
    input  l1_cache_pkg::word_t       proc_wdata,
    input  wire logic                 hit,
    input  l1_cache_pkg::way_t        hit_way,
    input  l1_cache_pkg::way_t        victim_way,
    input  l1_cache_pkg::set_idx_t    req_set,
    input  l1_cache_pkg::word_idx_t   req_word,
    input  l1_cache_pkg::tag_t        req_tag,
    input  wire logic                 fill_we,
    input  l1_cache_pkg::word_idx_t   fill_word_idx,
    input  l1_cache_pkg::word_t       fill_data,
    input  wire logic                 fill_done,
    input  l1_cache_pkg::word_idx_t   wb_word_idx,
    output l1_cache_pkg::tag_t        way_tag [2],
    output logic [1:0]                way_valid,
    output logic [1:0]                way_dirty,
    output l1_cache_pkg::way_t        lru_way,
    output l1_cache_pkg::word_t       wb_data,
    output l1_cache_pkg::word_t       proc_rdata
);
    import l1_cache_pkg::*;

    // line state, cleared on reset
    logic [1:0][`L1_SETS-1:0] valid_q;
    logic [1:0][`L1_SETS-1:0] dirty_q;
    logic [`L1_SETS-1:0]      lru_q;       // last used way per set

    // payload arrays
    tag_t  tag_q  [2][`L1_SETS];
    word_t data_q [2][`L1_SETS][`L1_BLOCK_WORDS];

    logic hit_wr;                          // write completing this edge

    assign hit_wr = hit && proc_wen;       // hit means busy is low

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (fill_done) begin
                valid_q[victim_way][req_set] <= 1'b1;
                dirty_q[victim_way][req_set] <= 1'b0; // fresh copy of memory
            end
            if (hit_wr) begin
                dirty_q[hit_way][req_set] <= 1'b1;
            end
            if (hit) begin
                lru_q[req_set] <= hit_way;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_we) begin
            data_q[victim_way][req_set][fill_word_idx] <= fill_data;
        end
        if (fill_done) begin
            tag_q[victim_way][req_set] <= req_tag;
        end
        if (hit_wr) begin
            data_q[hit_way][req_set][req_word] <= proc_wdata;
        end
    end

    // per-way view of the addressed set for the lookup
    assign way_tag[0]   = tag_q[0][req_set];
    assign way_tag[1]   = tag_q[1][req_set];
    assign way_valid[0] = valid_q[0][req_set];
    assign way_valid[1] = valid_q[1][req_set];
    assign way_dirty[0] = dirty_q[0][req_set];
    assign way_dirty[1] = dirty_q[1][req_set];
    assign lru_way      = way_t'(lru_q[req_set]);

    assign wb_data    = data_q[victim_way][req_set][wb_word_idx];
    assign proc_rdata = data_q[hit_way][req_set][req_word];

    // fills only run while the request misses
    a_fill_vs_hit: assert property (@(posedge CLK) disable iff (!nRST)
        !(fill_we && hit_wr))
        else $error("l1_data_store: fill write during hit write, set %0d", req_set);

endmodule

`default_nettype wire

/* l1_miss_ctrl.sv */
// l1 miss controller: FSM and word counter for write-back and fill bursts on the memory bus
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_cfg.svh"

module l1_miss_ctrl (
    input  wire logic                 CLK,
    input  wire logic                 nRST,
    input  wire logic                 miss,
    input  wire logic                 victim_dirty,
    input  l1_cache_pkg::tag_t        victim_tag,
    input  l1_cache_pkg::tag_t        req_tag,
    input  l1_cache_pkg::set_idx_t    req_set,
    input  l1_cache_pkg::word_t       wb_data,      // victim word at wb_word_idx
    input  l1_cache_pkg::word_t       mem_rdata,
    input  wire logic                 mem_busy,
    output logic                      mem_ren,
    output logic                      mem_wen,
    output l1_cache_pkg::word_t       mem_addr,
    output l1_cache_pkg::word_t       mem_wdata,
    output logic                      fill_we,
    output l1_cache_pkg::word_idx_t   fill_word_idx,
    output l1_cache_pkg::word_t       fill_data,
    output logic                      fill_done,
    output l1_cache_pkg::word_idx_t   wb_word_idx
);
    import l1_cache_pkg::*;

    localparam word_idx_t LAST_WORD = word_idx_t'(`L1_BLOCK_WORDS - 1);

    miss_state_t state, state_d;
    word_idx_t   cnt, cnt_d;     // beat within the burst
    logic        beat_done;      // memory accepted this beat
    logic        last_beat;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_d;
            cnt   <= cnt_d;
        end
    end

    // bus strobes follow the state directly
    assign mem_wen   = (state == WRITEBACK);
    assign mem_ren   = (state == FILL);
    assign beat_done = (mem_ren || mem_wen) && !mem_busy;
    assign last_beat = (cnt == LAST_WORD);

    // wb goes to the victim's old block, fill reads the requested block
    assign mem_addr  = {(state == WRITEBACK) ? victim_tag : req_tag, req_set, cnt, 2'b00};
    assign mem_wdata = wb_data;

    assign wb_word_idx   = cnt;
    assign fill_word_idx = cnt;
    assign fill_data     = mem_rdata;    // valid in the cycle busy drops
    assign fill_we       = mem_ren && beat_done;
    assign fill_done     = fill_we && last_beat; // store sets tag/valid, clears dirty

    always_comb begin
        state_d = state;
        cnt_d   = cnt;
        case (state)
            IDLE: begin
                cnt_d = '0;
                if (miss) begin
                    state_d = victim_dirty ? WRITEBACK : FILL;
                end
            end
            WRITEBACK: begin
                if (beat_done) begin
                    cnt_d = cnt + 1'b1;
                    if (last_beat) begin
                        cnt_d   = '0;    // fill starts at word 0
                        state_d = FILL;
                    end
                end
            end
            FILL: begin
                if (beat_done) begin
                    cnt_d = cnt + 1'b1;
                    if (last_beat) begin
                        cnt_d   = '0;
                        state_d = IDLE; // request hits next cycle
                    end
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // memory bus rules toward the memory model
    a_addr_held: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=> $stable(mem_addr) && (mem_ren || mem_wen))
        else $error("l1_miss_ctrl: beat changed while memory busy");

endmodule

`default_nettype wire

/* l1_tag_lookup.sv */
// l1 tag lookup: splits the request address, compares both ways and picks hit and victim
`timescale 1ns/1ps
`default_nettype none

module l1_tag_lookup (
    input  wire logic                 proc_ren,
    input  wire logic                 proc_wen,
    input  l1_cache_pkg::word_t       proc_addr,
    input  l1_cache_pkg::tag_t        way_tag [2],
    input  wire logic [1:0]           way_valid,
    input  wire logic [1:0]           way_dirty,
    input  l1_cache_pkg::way_t        lru_way,    // most recently used way of the set
    output l1_cache_pkg::tag_t        req_tag,
    output l1_cache_pkg::set_idx_t    req_set,
    output l1_cache_pkg::word_idx_t   req_word,
    output logic                      hit,
    output l1_cache_pkg::way_t        hit_way,
    output l1_cache_pkg::way_t        victim_way,
    output logic                      victim_dirty,
    output l1_cache_pkg::tag_t        victim_tag,
    output logic                      miss
);
    import l1_cache_pkg::*;

    req_op_t    op;
    logic [1:0] match; // per-way tag match on a valid line

    // write wins if both strobes are up
    assign op = proc_wen ? OP_WRITE : (proc_ren ? OP_READ : OP_NONE);

    // address fields: tag | set | word | byte
    assign req_word = proc_addr[2 +: WORD_IDX_BITS];
    assign req_set  = proc_addr[2 + WORD_IDX_BITS +: SET_BITS];
    assign req_tag  = proc_addr[2 + WORD_IDX_BITS + SET_BITS +: TAG_BITS];

    assign match[0] = way_valid[0] && (way_tag[0] == req_tag);
    assign match[1] = way_valid[1] && (way_tag[1] == req_tag);

    assign hit     = (op != OP_NONE) && (match != 2'b00);
    assign hit_way = way_t'(match[1]);          // way 0 unless way 1 matched
    assign miss    = (op != OP_NONE) && !hit;

    // replace the way not used last
    assign victim_way   = ~lru_way;
    assign victim_tag   = way_tag[victim_way];
    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way]; // only a live line needs wb

    // fills always land in the victim, so a tag can only live in one way
    always_comb begin
        assert #0 (match != 2'b11)
            else $error("l1_tag_lookup: tag present in both ways of set %0d", req_set);
        if (op != OP_NONE) begin
            assert #0 (proc_addr[1:0] == 2'b00)
                else $error("l1_tag_lookup: unaligned word access %h", proc_addr);
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
l1_cache_pkg.sv
l1_tag_lookup.sv
l1_miss_ctrl.sv
l1_data_store.sv
l1_cache.sv
tb_mem_model.sv
tb_l1_cache.sv

/* tb_l1_cache.sv */
// l1 cache testbench: file-driven processor requests against a stalling memory model
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_cfg.svh"

module tb_l1_cache;
    import l1_cache_pkg::*;

    localparam int    CLK_PERIOD = 40;
    localparam int    COLS       = 6;               // op addr wdata rdata fill wb
    localparam int    MAX_REQ    = 64;
    localparam word_t FILL_KEY   = 32'hA5A5_0000;

    logic  CLK;
    logic  nRST;
    logic  proc_ren;
    logic  proc_wen;
    word_t proc_addr;
    word_t proc_wdata;
    word_t proc_rdata;
    logic  proc_busy;
    logic  mem_ren;
    logic  mem_wen;
    word_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_busy;

    word_t vec [COLS*MAX_REQ];  // flat request table from the input file
    word_t shadow [word_t];     // processor view of memory, written words only
    int    n_req;
    int    n_fail;
    int    errors;              // main process checks
    int    mon_errors;          // bus monitor checks
    int    fill_total;          // completed read beats since start
    int    wb_total;            // completed write beats since start
    logic  load_done;

    l1_cache i_l1_cache (
        .CLK, .nRST,
        .proc_ren, .proc_wen, .proc_addr, .proc_wdata, .proc_rdata, .proc_busy,
        .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_rdata, .mem_busy
    );

    tb_mem_model i_mem_model (
        .CLK, .nRST, .mem_ren, .mem_wen, .mem_addr, .mem_wdata, .mem_rdata, .mem_busy
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD/2) CLK = ~CLK;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp,
                              inout int err_cnt);
        if (got !== exp) begin
            $display("FAILED %0t ns %s: got %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp,
                              inout int err_cnt);
        if (got !== exp) begin
            $display("FAILED %0t ns %s: got %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // what memory should hold after all processor writes so far
    function automatic word_t expect_mem(input word_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ FILL_KEY;
    endfunction

    // memory bus monitor, beats counted on completion
    initial begin
        mon_errors = 0;
        fill_total = 0;
        wb_total   = 0;
    end

    always @(posedge CLK) begin
        check_flag("mem_ren && mem_wen", mem_ren && mem_wen, 1'b0, mon_errors);
        if (!nRST) begin
            check_flag("mem_ren", mem_ren, 1'b0, mon_errors);   // quiet bus in reset
            check_flag("mem_wen", mem_wen, 1'b0, mon_errors);
        end
        if (mem_ren && !mem_busy) begin
            fill_total++;
        end
        if (mem_wen && !mem_busy) begin
            wb_total++;
            check_word("mem_wdata", mem_wdata, expect_mem(mem_addr), mon_errors);
        end
    end

    initial begin
        int      base;
        int      err_before;
        int      fill_start;
        int      wb_start;
        req_op_t op;
        word_t   addr;
        word_t   wdata;
        word_t   got;
        logic    first_busy;

        void'($urandom(32'h2c6f_1d14));
        nRST       = 1'b0;
        proc_ren   = 1'b0;
        proc_wen   = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        errors     = 0;
        n_fail     = 0;
        load_done  = 1'b0;
        foreach (vec[k]) vec[k] = '0;       // zero op ends the table
        $readmemh("l1_cache_input.txt", vec);
        n_req = 0;
        while (n_req < MAX_REQ && vec[n_req*COLS] != '0) begin
            n_req++;
        end
        if (n_req == 0) begin
            $display("no requests found in l1_cache_input.txt");
        end
        load_done = 1'b1;

        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);                     // first cycle out of reset
        check_flag("mem_ren", mem_ren, 1'b0, errors);
        check_flag("mem_wen", mem_wen, 1'b0, errors);

        for (int i = 0; i < n_req; i++) begin
            base       = i * COLS;
            op         = req_op_t'(vec[base][1:0]);
            addr       = vec[base+1];
            wdata      = vec[base+2];
            err_before = errors + mon_errors;
            if (op != OP_READ && op != OP_WRITE) begin
                $display("req %0d: unknown operation code %h in the input file", i, vec[base]);
                errors++;
                n_fail++;
            end else begin
                @(posedge CLK);
                fill_start = fill_total;    // no beat runs on this edge
                wb_start   = wb_total;
                proc_addr  <= addr;
                proc_wdata <= wdata;
                proc_ren   <= (op == OP_READ);
                proc_wen   <= (op == OP_WRITE);
                @(posedge CLK);
                first_busy = proc_busy;     // busy seen in the request's first cycle
                while (proc_busy) @(posedge CLK);   // edge with busy low completes it
                got = proc_rdata;
                proc_ren <= 1'b0;
                proc_wen <= 1'b0;
                if (op == OP_READ) begin
                    check_word("proc_rdata", got, vec[base+3], errors);
                end else begin
                    shadow[addr] = wdata;
                end
                // a request that needs no fill must hit at once
                check_flag("proc_busy", first_busy, vec[base+4] != '0, errors);
                check_word("fill beats", word_t'(fill_total - fill_start), vec[base+4], errors);
                check_word("write-back beats", word_t'(wb_total - wb_start), vec[base+5],
                           errors);
                if (errors + mon_errors != err_before) begin
                    n_fail++;
                end
                $display("req %0d %s %h: %s", i, op.name(), addr,
                         (errors + mon_errors == err_before) ? "pass" : "fail");
            end
        end

        $display("%0d requests, %0d passed, %0d failed, %0d check errors",
                 n_req, n_req - n_fail, n_fail, errors + mon_errors);
        if (errors + mon_errors == 0 && n_req > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // worst case per request is a full write-back plus fill with maximum stalls
    initial begin
        wait (load_done === 1'b1);
        #((n_req * (2 * `L1_BLOCK_WORDS * 4 + 4) + 4) * CLK_PERIOD);
        $display("watchdog expired before all %0d requests completed", n_req);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb_mem_model.sv */
// behavioural word memory for the cache testbench with rule-based content and random busy stalls
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  wire logic                 CLK,
    input  wire logic                 nRST,
    input  wire logic                 mem_ren,
    input  wire logic                 mem_wen,
    input  wire l1_cache_pkg::word_t  mem_addr,
    input  wire l1_cache_pkg::word_t  mem_wdata,
    output l1_cache_pkg::word_t       mem_rdata,
    output logic                      mem_busy
);
    import l1_cache_pkg::*;

    localparam word_t FILL_KEY = 32'hA5A5_0000; // untouched word = address ^ key

    word_t mem [word_t];    // only written words are stored
    int    stall;           // wait cycles left for the current beat
    logic  beat;

    assign beat     = mem_ren || mem_wen;
    assign mem_busy = beat && (stall != 0);

    // read data valid in the cycle busy drops
    always_comb begin
        mem_rdata = mem.exists(mem_addr) ? mem[mem_addr] : (mem_addr ^ FILL_KEY);
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            stall <= 0;                         // first beat goes through at once
        end else if (beat) begin
            if (stall != 0) begin
                stall <= stall - 1;
            end else begin
                stall <= int'($urandom % 4);    // 0..3 stall for the next beat
            end
        end
    end

    // write beat lands on the edge where busy is low
    always @(posedge CLK) begin
        if (mem_wen && !mem_busy) begin
            mem[mem_addr] = mem_wdata;
        end
    end

endmodule

`default_nettype wire
